//--- compile.f
stcPkg.sv
stcRegs.sv
stcPeakTrack.sv
stcTauLock.sv
stcDacMux.sv
stcMonitor.sv
stcMonitor_assertions.sv
tbStcMonitor.sv

//--- run.sh
#!/bin/sh
# Builds and runs the STC monitor testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tbStcMonitor -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
    exit 0
fi
exit 1

//--- tbStcMonitor.sv
/*
 * Testbench for the STC monitor. Inputs change on the falling edge.
 * Expected values come from shadow registers and a reference window model.
 */

`timescale 1ns/1ns

module tbStcMonitor;

    localparam int NUM_WINDOWS = 18;
    localparam int MAX_CPB = 40;
    localparam int WATCHDOG_CYCLES = NUM_WINDOWS * (MAX_CPB + 4) * 2 + 1000;

    logic busClk = 1'b0;
    logic rstN, cs, wr0, wr1, wr2, wr3, sampleValid, lockStatus0, lockStatus1;
    logic [12:0] addr;
    logic [31:0] dataIn, dataOut;
    logic signed [15:0] ch0Sample, ch1Sample, dac0Out, dac1Out, dac2Out;
    logic signed [15:0] expDac0, expDac1, expDac2, win0 [0:63], win1 [0:63];
    logic signed [15:0] mPeak0 = 16'sd0, mPeak1 = 16'sd0;
    logic signed [5:0] mTau = 6'sd0;
    logic mLock0 = 1'b0, mLock1 = 1'b0, modelOn = 1'b0, dacValid = 1'b0;
    logic [15:0] shCpb = 16'd8;
    logic shInv = 1'b0;
    logic [11:0] shThresh = 12'h100;
    logic [3:0] shSel0 = 4'h0, shSel1 = 4'h0, shSel2 = 4'h0;
    logic [31:0] rngState = 32'h687c6665;

    stcMonitor u_dut (.*);

    always #2 busClk = ~busClk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic signed [15:0] satAbs(input logic signed [15:0] s);
        if (s == -16'sd32768) return 16'sd32767;
        return (s < 0) ? -s : s;
    endfunction

    // Reference model of one window: peaks, first index on ties, tau and lock.
    function automatic void refWindow(input int len, output logic signed [15:0] mag0,
            output logic signed [15:0] mag1, output logic signed [5:0] tau,
            output logic lock0, output logic lock1);
        int idx0 = 0;
        int idx1 = 0;
        int d;
        mag0 = satAbs(win0[0]);
        mag1 = satAbs(win1[0]);
        for (int i = 1; i < len; i++) begin
            if (satAbs(win0[i]) > mag0) begin
                mag0 = satAbs(win0[i]);
                idx0 = i;
            end
            if (satAbs(win1[i]) > mag1) begin
                mag1 = satAbs(win1[i]);
                idx1 = i;
            end
        end
        d = idx1 - idx0;
        d = (d > 31) ? 31 : ((d < -32) ? -32 : d);
        if (shInv) d = (d == -32) ? 31 : -d;
        tau = d[5:0];
        lock0 = $unsigned(mag0) >= {4'h0, shThresh};
        lock1 = $unsigned(mag1) >= {4'h0, shThresh};
    endfunction

    function automatic logic signed [15:0] refDac(input logic [3:0] sel);
        case (sel)
            stcPkg::DAC_SRC_CH0:   return ch0Sample;
            stcPkg::DAC_SRC_CH1:   return ch1Sample;
            stcPkg::DAC_SRC_PEAK0: return mPeak0;
            stcPkg::DAC_SRC_PEAK1: return mPeak1;
            stcPkg::DAC_SRC_TAU:   return {{10{mTau[5]}}, mTau};
            default:               return 16'sd0;
        endcase
    endfunction

    function automatic logic [31:0] expRead(input logic [12:0] a);
        case (a)
            stcPkg::ADDR_CLOCKS_PER_BIT: return {15'h0, shInv, shCpb};
            stcPkg::ADDR_HX_THRESH:      return {20'h0, shThresh};
            stcPkg::ADDR_DAC_SELECT:     return {12'h0, shSel2, 4'h0, shSel1, 4'h0, shSel0};
            stcPkg::ADDR_PEAK_MAGS:      return {mPeak1, mPeak0};
            stcPkg::ADDR_DELTA_TAU:      return {mLock0, mLock1, 24'h0, mTau};
            default:                     return 32'h0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic driveIdle();
        rngState = xorshift(rngState);
        sampleValid = 1'b0;
        ch0Sample = rngState[15:0];
        ch1Sample = rngState[31:16];
    endtask

    task automatic busWrite(input logic [12:0] a, input logic [31:0] d, input logic [3:0] s);
        @(negedge busClk);
        cs = 1'b1;
        addr = a;
        dataIn = d;
        {wr3, wr2, wr1, wr0} = s;
        @(negedge busClk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        if (a == stcPkg::ADDR_CLOCKS_PER_BIT) begin
            if (s[0]) shCpb[7:0] = d[7:0];
            if (s[1]) shCpb[15:8] = d[15:8];
            if (s[2]) shInv = d[16];
        end else if (a == stcPkg::ADDR_HX_THRESH) begin
            if (s[0]) shThresh[7:0] = d[7:0];
            if (s[1]) shThresh[11:8] = d[11:8];
        end else if (a == stcPkg::ADDR_DAC_SELECT) begin
            if (s[0]) shSel0 = d[3:0];
            if (s[1]) shSel1 = d[11:8];
            if (s[2]) shSel2 = d[19:16];
        end
    endtask

    task automatic busRead(input logic [12:0] a, input string name);
        @(negedge busClk);
        cs = 1'b1;
        addr = a;
        #1 check(name, dataOut, expRead(a));
        @(negedge busClk);
        cs = 1'b0;
    endtask

    // Small noise everywhere, then one strong peak per channel.
    task automatic buildWindow(input int p0, input logic signed [15:0] amp0,
            input int p1, input logic signed [15:0] amp1);
        for (int i = 0; i < 64; i++) begin
            rngState = xorshift(rngState);
            win0[i] = {{10{rngState[5]}}, rngState[5:0]};
            win1[i] = {{10{rngState[21]}}, rngState[21:16]};
        end
        win0[p0] = amp0;
        win1[p1] = amp1;
    endtask

    // Feeds one window with occasional gaps and moves the model along the pipeline.
    task automatic feedWindow();
        int len;
        logic signed [15:0] m0, m1;
        logic signed [5:0] t;
        logic l0, l1;
        len = (shCpb < 16'd2) ? 2 : int'(shCpb);
        refWindow(len, m0, m1, t, l0, l1);
        for (int i = 0; i < len; i++) begin
            if (rngState[3:0] == 4'h0) begin
                @(negedge busClk);
                driveIdle();
            end
            @(negedge busClk);
            rngState = xorshift(rngState);
            sampleValid = 1'b1;
            ch0Sample = win0[i];
            ch1Sample = win1[i];
        end
        @(negedge busClk);
        driveIdle();
        check("peakValid", {31'h0, u_dut.ch0PeakValid}, 32'h1);
        mPeak0 = m0;
        mPeak1 = m1;
        @(negedge busClk);
        driveIdle();
        {mTau, mLock0, mLock1} = {t, l0, l1};
        check("lockStatus0", {31'h0, lockStatus0}, {31'h0, mLock0});
        check("lockStatus1", {31'h0, lockStatus1}, {31'h0, mLock1});
    endtask

    // Compare process for the DAC outputs, one cycle behind their sources.
    always @(posedge busClk) begin
        if (modelOn) begin
            expDac0 <= refDac(shSel0);
            expDac1 <= refDac(shSel1);
            expDac2 <= refDac(shSel2);
            dacValid <= 1'b1;
        end
    end

    always @(negedge busClk) begin
        if (dacValid) begin
            check("dac0Out", {16'h0, dac0Out}, {16'h0, expDac0});
            check("dac1Out", {16'h0, dac1Out}, {16'h0, expDac1});
            check("dac2Out", {16'h0, dac2Out}, {16'h0, expDac2});
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge busClk);
        $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] oldPeaks;
        {rstN, cs, wr0, wr1, wr2, wr3, sampleValid} = 7'h0;
        {addr, dataIn, ch0Sample, ch1Sample} = '0;
        repeat (16) @(negedge busClk);
        rstN = 1'b1;
        modelOn = 1'b1;

        // Register access with partial strobes and unmapped addresses.
        busRead(stcPkg::ADDR_CLOCKS_PER_BIT, "clocksPerBit reg");
        busRead(stcPkg::ADDR_HX_THRESH, "hxThresh reg");
        busWrite(stcPkg::ADDR_HX_THRESH, 32'h0000_0ABC, 4'b0001);
        busRead(stcPkg::ADDR_HX_THRESH, "hxThresh lane0");
        busWrite(stcPkg::ADDR_HX_THRESH, 32'h0000_0A00, 4'b0010);
        busRead(stcPkg::ADDR_HX_THRESH, "hxThresh lane1");
        busWrite(stcPkg::ADDR_DAC_SELECT, 32'h0000_0500, 4'b0010);
        busWrite(stcPkg::ADDR_DAC_SELECT, 32'h0003_0F02, 4'b0101);
        busRead(stcPkg::ADDR_DAC_SELECT, "dacSelect reg");
        busWrite(stcPkg::ADDR_CLOCKS_PER_BIT, 32'hFF01_FFFF, 4'b1100);
        busRead(stcPkg::ADDR_CLOCKS_PER_BIT, "clocksPerBit lane2");
        busWrite(stcPkg::ADDR_CLOCKS_PER_BIT, 32'h0000_0006, 4'b0111);
        busWrite(stcPkg::ADDR_HX_THRESH, 32'h0000_0100, 4'b0011);
        busWrite(stcPkg::ADDR_DAC_SELECT, 32'h0, 4'b0111);
        busRead(13'h0000, "unmapped 0x0000");
        busRead(13'h0105, "unmapped 0x0105");

        // Saturated most negative sample, ties and random windows.
        buildWindow(2, -16'sd32768, 1, 16'sd100);
        win0[4] = 16'sd32767;
        win1[5] = -16'sd100;
        feedWindow();
        busRead(stcPkg::ADDR_PEAK_MAGS, "peak mags");
        busRead(stcPkg::ADDR_DELTA_TAU, "delta tau");
        for (int w = 0; w < 4; w++) begin
            for (int i = 0; i < 64; i++) begin
                rngState = xorshift(rngState);
                {win1[i], win0[i]} = rngState;
            end
            feedWindow();
            busRead(stcPkg::ADDR_PEAK_MAGS, "peak mags random");
        end

        // Tau clamp, in range, then the same windows inverted.
        busWrite(stcPkg::ADDR_CLOCKS_PER_BIT, 32'h0000_0028, 4'b0011);
        for (int inv = 0; inv < 2; inv++) begin
            busWrite(stcPkg::ADDR_CLOCKS_PER_BIT, {15'h0, inv[0], 16'h0}, 4'b0100);
            buildWindow(0, 16'sd1000, 39, 16'sd900);
            feedWindow();
            busRead(stcPkg::ADDR_DELTA_TAU, "delta tau high");
            buildWindow(39, 16'sd1000, 0, 16'sd900);
            feedWindow();
            busRead(stcPkg::ADDR_DELTA_TAU, "delta tau low");
            buildWindow(5, 16'sd1000, 12, 16'sd900);
            feedWindow();
            busRead(stcPkg::ADDR_DELTA_TAU, "delta tau mid");
        end

        // Threshold below, equal to and above the channel 0 peak.
        busWrite(stcPkg::ADDR_CLOCKS_PER_BIT, 32'h0000_0008, 4'b0111);
        for (int k = 0; k < 3; k++) begin
            busWrite(stcPkg::ADDR_HX_THRESH, 32'h0000_02FF + k, 4'b0011);
            buildWindow(3, 16'sh0300, 6, 16'sh0200);
            feedWindow();
            busRead(stcPkg::ADDR_DELTA_TAU, "lock flags");
        end

        // Readback stays frozen while cs is held high across a window end.
        buildWindow(1, 16'sh1234, 2, 16'sh0456);
        feedWindow();
        busRead(stcPkg::ADDR_PEAK_MAGS, "peak mags before hold");
        oldPeaks = {mPeak1, mPeak0};
        @(negedge busClk);
        cs = 1'b1;
        addr = stcPkg::ADDR_PEAK_MAGS;
        buildWindow(4, 16'sh2222, 5, 16'sh0333);
        feedWindow();
        #1 check("peak mags frozen", dataOut, oldPeaks);
        @(negedge busClk);
        cs = 1'b0;
        busRead(stcPkg::ADDR_PEAK_MAGS, "peak mags after hold");

        // DAC sources, including invalid codes. A negative tau shows the sign extension.
        busWrite(stcPkg::ADDR_DAC_SELECT, 32'h0004_0302, 4'b0111);
        buildWindow(6, -16'sd700, 2, 16'sd500);
        feedWindow();
        busWrite(stcPkg::ADDR_DAC_SELECT, 32'h000F_0701, 4'b0111);
        buildWindow(6, 16'sd800, 1, -16'sd600);
        feedWindow();
        busRead(stcPkg::ADDR_DAC_SELECT, "dacSelect final");
        repeat (4) @(negedge busClk);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- stcMonitor_assertions.sv
/*
 * Bus and output checks for the STC monitor, bound to the top level.
 */

`timescale 1ns/1ns

module stcMonitorAssertions (
    input logic                                busClk,
    input logic                                rstN,
    input logic                                cs,
    input logic [31:0]                         dataOut,
    input logic                                lockStatus0,
    input logic                                lockStatus1,
    input logic signed [stcPkg::SAMPLE_W-1:0]  dac0Out,
    input logic signed [stcPkg::SAMPLE_W-1:0]  dac1Out,
    input logic signed [stcPkg::SAMPLE_W-1:0]  dac2Out
);

    knownOutputs: assert property (@(posedge busClk) disable iff (!rstN)
        !$isunknown({lockStatus0, lockStatus1, dataOut}))
        else $error("lock flags or read data unknown");

    idleBusZero: assert property (@(posedge busClk) disable iff (!rstN)
        !cs |-> dataOut == 32'h0)
        else $error("read data not zero with cs low");

    // The DAC registers use the asynchronous reset, so they read zero at every edge in reset.
    dacResetZero: assert property (@(posedge busClk)
        !rstN |-> (dac0Out == 16'sd0 && dac1Out == 16'sd0 && dac2Out == 16'sd0))
        else $error("DAC output not zero during reset");

endmodule

bind stcMonitor stcMonitorAssertions uAsserts (
    .busClk, .rstN, .cs, .dataOut, .lockStatus0, .lockStatus1, .dac0Out, .dac1Out, .dac2Out
);

//--- stcMonitor.sv
/*
 * STC timing monitor top level.
 * Both channels share one sample strobe and one window length, so their
 * windows stay aligned and channel 0's peakValid times the tau stage.
 */

`timescale 1ns/1ns

module stcMonitor (
    input  logic                                busClk,
    input  logic                                rstN,
    input  logic                                cs,
    input  logic                                wr0,
    input  logic                                wr1,
    input  logic                                wr2,
    input  logic                                wr3,
    input  logic [stcPkg::ADDR_W-1:0]           addr,
    input  logic [31:0]                         dataIn,
    output logic [31:0]                         dataOut,
    input  logic                                sampleValid,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  ch0Sample,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  ch1Sample,
    output logic signed [stcPkg::SAMPLE_W-1:0]  dac0Out,
    output logic signed [stcPkg::SAMPLE_W-1:0]  dac1Out,
    output logic signed [stcPkg::SAMPLE_W-1:0]  dac2Out,
    output logic                                lockStatus0,
    output logic                                lockStatus1
);

    logic [15:0]                        clocksPerBit;
    logic                               spectrumInvert;
    logic [stcPkg::THRESH_W-1:0]        hxThreshSlv;
    logic [stcPkg::SEL_W-1:0]           dac0Select;
    logic [stcPkg::SEL_W-1:0]           dac1Select;
    logic [stcPkg::SEL_W-1:0]           dac2Select;
    logic signed [stcPkg::SAMPLE_W-1:0] ch0Mag;
    logic signed [stcPkg::SAMPLE_W-1:0] ch1Mag;
    logic [15:0]                        ch0Index;
    logic [15:0]                        ch1Index;
    logic                               ch0PeakValid;
    logic signed [stcPkg::TAU_W-1:0]    deltaTau;

    stcRegs uRegs (
        .busClk, .rstN, .cs, .wr0, .wr1, .wr2, .wr3, .addr, .dataIn, .dataOut,
        .ch0Mag, .ch1Mag, .deltaTau, .lockStatus0, .lockStatus1,
        .clocksPerBit, .spectrumInvert, .hxThreshSlv,
        .dac0Select, .dac1Select, .dac2Select
    );

    stcPeakTrack uPeak0 (
        .busClk, .rstN, .sampleValid,
        .sample(ch0Sample), .clocksPerBit,
        .peakMag(ch0Mag), .peakIndex(ch0Index), .peakValid(ch0PeakValid)
    );

    // Channel 1 ends its windows on the same edge as channel 0.
    stcPeakTrack uPeak1 (
        .busClk, .rstN, .sampleValid,
        .sample(ch1Sample), .clocksPerBit,
        .peakMag(ch1Mag), .peakIndex(ch1Index), .peakValid()
    );

    stcTauLock uTauLock (
        .busClk, .rstN, .peakValid(ch0PeakValid),
        .peakMag0(ch0Mag), .peakMag1(ch1Mag),
        .peakIndex0(ch0Index), .peakIndex1(ch1Index),
        .spectrumInvert, .hxThreshSlv,
        .deltaTau, .lockStatus0, .lockStatus1
    );

    stcDacMux uDacMux (
        .busClk, .rstN, .ch0Sample, .ch1Sample,
        .peakMag0(ch0Mag), .peakMag1(ch1Mag), .deltaTau,
        .dac0Select, .dac1Select, .dac2Select,
        .dac0Out, .dac1Out, .dac2Out
    );

endmodule

//--- stcDacMux.sv
/*
 * Three registered DAC outputs, each picking a source by its select code.
 * Unknown select codes drive zero. Tau is sign-extended to the DAC width.
 */

`timescale 1ns/1ns

module stcDacMux (
    input  logic                                busClk,
    input  logic                                rstN,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  ch0Sample,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  ch1Sample,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  peakMag0,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  peakMag1,
    input  logic signed [stcPkg::TAU_W-1:0]     deltaTau,
    input  logic [stcPkg::SEL_W-1:0]            dac0Select,
    input  logic [stcPkg::SEL_W-1:0]            dac1Select,
    input  logic [stcPkg::SEL_W-1:0]            dac2Select,
    output logic signed [stcPkg::SAMPLE_W-1:0]  dac0Out,
    output logic signed [stcPkg::SAMPLE_W-1:0]  dac1Out,
    output logic signed [stcPkg::SAMPLE_W-1:0]  dac2Out
);

    logic signed [stcPkg::SAMPLE_W-1:0] tauExt;

    assign tauExt = {{(stcPkg::SAMPLE_W-stcPkg::TAU_W){deltaTau[stcPkg::TAU_W-1]}}, deltaTau};

    function automatic logic signed [stcPkg::SAMPLE_W-1:0] pickSource(
        input logic [stcPkg::SEL_W-1:0] sel
    );
        case (sel)
            stcPkg::DAC_SRC_CH0:   return ch0Sample;
            stcPkg::DAC_SRC_CH1:   return ch1Sample;
            stcPkg::DAC_SRC_PEAK0: return peakMag0;
            stcPkg::DAC_SRC_PEAK1: return peakMag1;
            stcPkg::DAC_SRC_TAU:   return tauExt;
            default:               return '0;
        endcase
    endfunction

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            dac0Out <= '0;
            dac1Out <= '0;
            dac2Out <= '0;
        end else begin
            dac0Out <= pickSource(dac0Select);
            dac1Out <= pickSource(dac1Select);
            dac2Out <= pickSource(dac2Select);
        end
    end

endmodule

//--- stcTauLock.sv
/*
 * Turns the two channel peaks into a delta tau and two lock flags.
 * Tau is the index difference clamped to the signed TAU_W range, then
 * negated when the spectrum is inverted. Results change only on peakValid.
 */

`timescale 1ns/1ns

module stcTauLock (
    input  logic                                busClk,
    input  logic                                rstN,
    input  logic                                peakValid,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  peakMag0,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  peakMag1,
    input  logic [15:0]                         peakIndex0,
    input  logic [15:0]                         peakIndex1,
    input  logic                                spectrumInvert,
    input  logic [stcPkg::THRESH_W-1:0]         hxThreshSlv,
    output logic signed [stcPkg::TAU_W-1:0]     deltaTau,
    output logic                                lockStatus0,
    output logic                                lockStatus1
);

    logic signed [16:0]                 diff;
    logic                               fits;
    logic signed [stcPkg::TAU_W-1:0]    clamped;
    logic signed [stcPkg::TAU_W-1:0]    tauNext;
    logic [stcPkg::SAMPLE_W-1:0]        threshExt;

    assign diff = $signed({1'b0, peakIndex1}) - $signed({1'b0, peakIndex0});

    // The difference fits when every bit above the tau sign bit matches the sign.
    assign fits = (diff[16:stcPkg::TAU_W-1] == {(18-stcPkg::TAU_W){diff[16]}});

    always_comb begin
        if (fits) begin
            clamped = diff[stcPkg::TAU_W-1:0];
        end else begin
            clamped = {diff[16], {(stcPkg::TAU_W-1){~diff[16]}}};
        end

        // Negating the most negative value saturates to the top of the range.
        tauNext = clamped;
        if (spectrumInvert) begin
            if (clamped == {1'b1, {(stcPkg::TAU_W-1){1'b0}}}) begin
                tauNext = {1'b0, {(stcPkg::TAU_W-1){1'b1}}};
            end else begin
                tauNext = -clamped;
            end
        end
    end

    assign threshExt = {{(stcPkg::SAMPLE_W-stcPkg::THRESH_W){1'b0}}, hxThreshSlv};

    // Peaks are never negative, so an unsigned compare is safe.
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            deltaTau    <= '0;
            lockStatus0 <= 1'b0;
            lockStatus1 <= 1'b0;
        end else if (peakValid) begin
            deltaTau    <= tauNext;
            lockStatus0 <= $unsigned(peakMag0) >= threshExt;
            lockStatus1 <= $unsigned(peakMag1) >= threshExt;
        end
    end

endmodule

//--- stcPeakTrack.sv
/*
 * Finds the largest absolute sample and its 0-based position in each window.
 * A window is clocksPerBit valid samples, never fewer than two.
 * The window length is sampled on the first sample of each window.
 */

`timescale 1ns/1ns

module stcPeakTrack (
    input  logic                                busClk,
    input  logic                                rstN,
    input  logic                                sampleValid,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  sample,
    input  logic [15:0]                         clocksPerBit,
    output logic signed [stcPkg::SAMPLE_W-1:0]  peakMag,
    output logic [15:0]                         peakIndex,
    output logic                                peakValid
);

    logic [15:0]                        pos;
    logic [15:0]                        winLen;
    logic [15:0]                        effLen;
    logic signed [stcPkg::SAMPLE_W-1:0] absVal;
    logic signed [stcPkg::SAMPLE_W-1:0] runMax;
    logic [15:0]                        runIdx;
    logic                               newBetter;
    logic signed [stcPkg::SAMPLE_W-1:0] candMag;
    logic [15:0]                        candIdx;
    logic                               lastSample;

    assign effLen = (clocksPerBit < stcPkg::MIN_CLOCKS_PER_BIT) ?
                    stcPkg::MIN_CLOCKS_PER_BIT : clocksPerBit;

    // The most negative sample has no positive twin, so it saturates.
    always_comb begin
        if (sample == {1'b1, {(stcPkg::SAMPLE_W-1){1'b0}}}) begin
            absVal = {1'b0, {(stcPkg::SAMPLE_W-1){1'b1}}};
        end else if (sample < 0) begin
            absVal = -sample;
        end else begin
            absVal = sample;
        end
    end

    // Strict compare keeps the first occurrence on ties.
    assign newBetter = (pos == 16'd0) || (absVal > runMax);
    assign candMag   = newBetter ? absVal : runMax;
    assign candIdx   = newBetter ? pos : runIdx;

    // winLen is never below two, so the first sample cannot end a window.
    assign lastSample = (pos != 16'd0) && (pos == winLen - 16'd1);

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            pos       <= '0;
            winLen    <= stcPkg::CLOCKS_PER_BIT_RESET;
            runMax    <= '0;
            runIdx    <= '0;
            peakMag   <= '0;
            peakIndex <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= 1'b0;
            if (sampleValid) begin
                runMax <= candMag;
                runIdx <= candIdx;
                if (pos == 16'd0) begin
                    winLen <= effLen;
                end
                if (lastSample) begin
                    peakMag   <= candMag;
                    peakIndex <= candIdx;
                    peakValid <= 1'b1;
                    pos       <= '0;
                end else begin
                    pos <= pos + 16'd1;
                end
            end
        end
    end

endmodule

//--- stcRegs.sv
/*
 * Host register block on a chip-select bus with one write strobe per byte lane.
 * Lane 3 has no register behind it, so wr3 writes are accepted and dropped.
 * Peak and tau readbacks are sampled while cs is low and frozen while cs is high.
 */

`timescale 1ns/1ns

module stcRegs (
    input  logic                                busClk,
    input  logic                                rstN,
    input  logic                                cs,
    input  logic                                wr0,
    input  logic                                wr1,
    input  logic                                wr2,
    input  logic                                wr3,
    input  logic [stcPkg::ADDR_W-1:0]           addr,
    input  logic [31:0]                         dataIn,
    output logic [31:0]                         dataOut,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  ch0Mag,
    input  logic signed [stcPkg::SAMPLE_W-1:0]  ch1Mag,
    input  logic signed [stcPkg::TAU_W-1:0]     deltaTau,
    input  logic                                lockStatus0,
    input  logic                                lockStatus1,
    output logic [15:0]                         clocksPerBit,
    output logic                                spectrumInvert,
    output logic [stcPkg::THRESH_W-1:0]         hxThreshSlv,
    output logic [stcPkg::SEL_W-1:0]            dac0Select,
    output logic [stcPkg::SEL_W-1:0]            dac1Select,
    output logic [stcPkg::SEL_W-1:0]            dac2Select
);

    logic signed [stcPkg::SAMPLE_W-1:0] ch0MagHold;
    logic signed [stcPkg::SAMPLE_W-1:0] ch1MagHold;
    logic signed [stcPkg::TAU_W-1:0]    deltaTauHold;

    // Each strobe only touches its own byte lane of the addressed register.
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            clocksPerBit   <= stcPkg::CLOCKS_PER_BIT_RESET;
            spectrumInvert <= 1'b0;
            hxThreshSlv    <= stcPkg::HX_THRESH_RESET;
            dac0Select     <= '0;
            dac1Select     <= '0;
            dac2Select     <= '0;
        end else if (cs) begin
            if (wr0) begin
                case (addr)
                    stcPkg::ADDR_CLOCKS_PER_BIT: clocksPerBit[7:0] <= dataIn[7:0];
                    stcPkg::ADDR_HX_THRESH:      hxThreshSlv[7:0]  <= dataIn[7:0];
                    stcPkg::ADDR_DAC_SELECT:     dac0Select        <= dataIn[3:0];
                    default: ;
                endcase
            end
            if (wr1) begin
                case (addr)
                    stcPkg::ADDR_CLOCKS_PER_BIT: clocksPerBit[15:8] <= dataIn[15:8];
                    stcPkg::ADDR_HX_THRESH:      hxThreshSlv[11:8]  <= dataIn[11:8];
                    stcPkg::ADDR_DAC_SELECT:     dac1Select         <= dataIn[11:8];
                    default: ;
                endcase
            end
            if (wr2) begin
                case (addr)
                    stcPkg::ADDR_CLOCKS_PER_BIT: spectrumInvert <= dataIn[16];
                    stcPkg::ADDR_DAC_SELECT:     dac2Select     <= dataIn[19:16];
                    default: ;
                endcase
            end
            // wr3 would carry the center frequency, which this block does not hold.
        end
    end

    // Clocked stand-in for the old hold latches.
    // A read cycle keeps cs high, so the host sees one stable snapshot.
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            ch0MagHold   <= '0;
            ch1MagHold   <= '0;
            deltaTauHold <= '0;
        end else if (!cs) begin
            ch0MagHold   <= ch0Mag;
            ch1MagHold   <= ch1Mag;
            deltaTauHold <= deltaTau;
        end
    end

    // Read mux. Lock flags are live and not part of the snapshot.
    always_comb begin
        dataOut = 32'h0;
        if (cs) begin
            case (addr)
                stcPkg::ADDR_CLOCKS_PER_BIT: begin
                    dataOut = {15'h0, spectrumInvert, clocksPerBit};
                end
                stcPkg::ADDR_HX_THRESH: begin
                    dataOut = {20'h0, hxThreshSlv};
                end
                stcPkg::ADDR_DAC_SELECT: begin
                    dataOut = {12'h0, dac2Select, 4'h0, dac1Select, 4'h0, dac0Select};
                end
                stcPkg::ADDR_PEAK_MAGS: begin
                    dataOut = {ch1MagHold, ch0MagHold};
                end
                stcPkg::ADDR_DELTA_TAU: begin
                    dataOut = {lockStatus0, lockStatus1, 24'h0, deltaTauHold};
                end
                default: begin
                    dataOut = 32'h0;
                end
            endcase
        end
    end

endmodule

//--- stcPkg.sv
/*
 * Shared constants for the STC timing monitor.
 * Register addresses are word addresses on the 13-bit host bus.
 * Window lengths below MIN_CLOCKS_PER_BIT are raised to that floor.
 */

package stcPkg;

    // Datapath widths.
    localparam int SAMPLE_W = 16;
    localparam int TAU_W    = 6;
    localparam int ADDR_W   = 13;
    localparam int THRESH_W = 12;
    localparam int SEL_W    = 4;

    // Host register map.
    localparam logic [ADDR_W-1:0] ADDR_CLOCKS_PER_BIT = 13'h0100;
    localparam logic [ADDR_W-1:0] ADDR_HX_THRESH      = 13'h0101;
    localparam logic [ADDR_W-1:0] ADDR_DAC_SELECT     = 13'h0102;
    localparam logic [ADDR_W-1:0] ADDR_PEAK_MAGS      = 13'h0103;
    localparam logic [ADDR_W-1:0] ADDR_DELTA_TAU      = 13'h0104;

    // Bit period settings.
    localparam logic [15:0] CLOCKS_PER_BIT_RESET = 16'd8;
    localparam logic [15:0] MIN_CLOCKS_PER_BIT   = 16'd2;

    // Lock threshold after reset.
    localparam logic [THRESH_W-1:0] HX_THRESH_RESET = 12'h100;

    // DAC source select codes.
    // Codes not listed here drive the DAC to zero.
    localparam logic [SEL_W-1:0] DAC_SRC_CH0   = 4'd0;
    localparam logic [SEL_W-1:0] DAC_SRC_CH1   = 4'd1;
    localparam logic [SEL_W-1:0] DAC_SRC_PEAK0 = 4'd2;
    localparam logic [SEL_W-1:0] DAC_SRC_PEAK1 = 4'd3;
    localparam logic [SEL_W-1:0] DAC_SRC_TAU   = 4'd4;

endpackage
